//--- src/obj_macros.svh
//------------------------------
// Object table constants
// Table address width, bank size,
// frame length and end marker
//------------------------------
`ifndef OBJ_MACROS_SVH
`define OBJ_MACROS_SVH

// CPU word address width over both banks
// Bit 13 picks the bank, 12:3 the entry, 2:1 the field
`define OBJ_AW 13

// Entries held in one bank
// Four words per entry, two banks
`define OBJ_ENTRIES (1 << (`OBJ_AW - 3))

// Clock cycles between frame start pulses
`define OBJ_FRAME_CYCLES 4096

// Attribute word that terminates the table
`define OBJ_END_ATTR 16'hFF00

`endif

//--- src/obj_pkg.sv
//------------------------------
// Object table types
// Word, byte lanes, entry index,
// scan FSM states
//------------------------------
`default_nettype none

`include "obj_macros.svh"

package obj_pkg;

    // One table field, X, Y, code or attribute
    typedef logic [15:0] obj_word_t;

    // Byte lanes, bit 1 is the upper byte
    // Active low on the CPU side, active high at the RAM
    typedef logic [1:0] obj_be_t;

    // Entry number within one bank
    // Address minus field bits and bank bit
    typedef logic [`OBJ_AW-4:0] obj_idx_t;

    // Scan FSM states
    // IDLE   waiting for frame start
    // FETCH  index on the RAM address
    // WAIT   RAM read in flight
    // HOLD   entry presented until accepted
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FETCH = 2'd1,
        WAIT  = 2'd2,
        HOLD  = 2'd3
    } scan_state_t;

endpackage

`default_nettype wire

//--- src/obj_dpram.sv
//------------------------------
// Dual-port RAM, 16-bit word
// Byte-enabled write port
// Registered read port
//------------------------------
`default_nettype none

module obj_dpram #(
    parameter int AW = 11
) (
    input  wire logic               clk_cpu,

    // Write port, one enable per byte
    input  obj_pkg::obj_be_t        we,
    input  wire logic [AW-1:0]      wr_addr,
    input  obj_pkg::obj_word_t      wr_data,

    // Read port, data one cycle after address
    input  wire logic [AW-1:0]      rd_addr,
    output obj_pkg::obj_word_t      rd_data
);

    // Storage for both banks of one field
    obj_pkg::obj_word_t mem [0:(1 << AW)-1];

    // Write side
    // Each lane is written on its own
    always_ff @(posedge clk_cpu) begin
        for (int b = 0; b < 2; b++) begin
            if (we[b]) begin
                mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    // Read side
    // Same-address collision returns the old word
    always_ff @(posedge clk_cpu) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- src/obj_ram.sv
//------------------------------
// Double-buffered object RAM
// CPU write decode, bank select,
// write acknowledge
//------------------------------
`default_nettype none

`include "obj_macros.svh"

module obj_ram (
    input  wire logic                   clk_cpu,
    input  wire logic                   rst_n,

    // Active bank from the frame timer
    input  wire logic                   obank,

    // CPU write side
    input  wire logic                   cs,
    output logic                        ok,
    input  obj_pkg::obj_be_t            dsn,
    input  wire logic [`OBJ_AW:1]       main_addr,
    input  obj_pkg::obj_word_t          main_dout,

    // Display read side
    input  obj_pkg::obj_idx_t           obj_addr,
    output obj_pkg::obj_word_t          obj_x,
    output obj_pkg::obj_word_t          obj_y,
    output obj_pkg::obj_word_t          obj_code,
    output obj_pkg::obj_word_t          obj_attr
);

    // Table address is bank bit plus entry index
    localparam int TAW = `OBJ_AW - 2;

    logic [1:0]             field_sel;
    logic [TAW-1:0]         wr_addr;
    logic [TAW-1:0]         rd_addr;
    obj_pkg::obj_be_t       field_we [4];
    obj_pkg::obj_word_t     field_q  [4];

    // Field order in the address
    // 0 X, 1 Y, 2 code, 3 attribute
    assign field_sel = main_addr[2:1];

    // CPU bank bit is relative to the active bank
    assign wr_addr = {obank ^ main_addr[`OBJ_AW], main_addr[`OBJ_AW-1:3]};

    // Display always reads the bank the CPU is not using
    assign rd_addr = {~obank, obj_addr};

    // One table per field, all on the same addresses
    // so an entry's four words come out together
    for (genvar f = 0; f < 4; f++) begin : g_field
        // Low dsn bits enable their bytes
        assign field_we[f] = (cs && field_sel == 2'(f)) ? ~dsn : 2'b00;

        obj_dpram #(
            .AW         (TAW)
        ) u_table (
            .clk_cpu    (clk_cpu),
            .we         (field_we[f]),
            .wr_addr    (wr_addr),
            .wr_data    (main_dout),
            .rd_addr    (rd_addr),
            .rd_data    (field_q[f])
        );
    end

    assign obj_x    = field_q[0];
    assign obj_y    = field_q[1];
    assign obj_code = field_q[2];
    assign obj_attr = field_q[3];

    // Write takes one cycle, ack follows cs
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            ok <= 1'b0;
        end else begin
            ok <= cs;
        end
    end

endmodule

`default_nettype wire

//--- src/obj_frame_timer.sv
//------------------------------
// Frame timer
// Frame start pulse and active
// bank register
//------------------------------
`default_nettype none

`include "obj_macros.svh"

module obj_frame_timer (
    input  wire logic   clk_cpu,
    input  wire logic   rst_n,

    // Requested bank, taken only at frame start
    input  wire logic   bank_sel,

    output logic        frame_start,
    output logic        obank
);

    localparam int CW = $clog2(`OBJ_FRAME_CYCLES);

    logic [CW-1:0]  cnt;
    logic           wrap;

    // Last cycle of the frame
    assign wrap = (cnt == CW'(`OBJ_FRAME_CYCLES - 1));

    // Counter runs a full frame before the first pulse
    // obank moves in the same edge as frame_start rises
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            cnt         <= '0;
            frame_start <= 1'b0;
            obank       <= 1'b0;
        end else begin
            frame_start <= wrap;
            if (wrap) begin
                cnt   <= '0;
                // Swap only here, never mid frame
                obank <= bank_sel;
            end else begin
                cnt   <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/obj_scan_fsm.sv
//------------------------------
// Object scan FSM
// Walks the display bank and
// streams entries with valid/ready
//------------------------------
`default_nettype none

`include "obj_macros.svh"

module obj_scan_fsm (
    input  wire logic           clk_cpu,
    input  wire logic           rst_n,

    // Scan trigger
    input  wire logic           frame_start,

    // RAM read side
    output obj_pkg::obj_idx_t   obj_addr,
    input  obj_pkg::obj_word_t  ram_x,
    input  obj_pkg::obj_word_t  ram_y,
    input  obj_pkg::obj_word_t  ram_code,
    input  obj_pkg::obj_word_t  ram_attr,

    // Sprite stream
    output logic                obj_valid,
    input  wire logic           obj_ready,
    output obj_pkg::obj_idx_t   obj_index,
    output obj_pkg::obj_word_t  obj_x,
    output obj_pkg::obj_word_t  obj_y,
    output obj_pkg::obj_word_t  obj_code,
    output obj_pkg::obj_word_t  obj_attr,

    output logic                scan_done
);

    localparam obj_pkg::obj_idx_t LAST_IDX = obj_pkg::obj_idx_t'(`OBJ_ENTRIES - 1);

    obj_pkg::scan_state_t   state;
    obj_pkg::obj_idx_t      idx;

    // Index goes straight to the RAM
    // read in FETCH, data valid in WAIT
    assign obj_addr = idx;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            state     <= obj_pkg::IDLE;
            idx       <= '0;
            obj_valid <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            // Done is a single-cycle pulse
            scan_done <= 1'b0;
            case (state)
                obj_pkg::IDLE: begin
                    // Frame start while busy is dropped
                    if (frame_start) begin
                        idx   <= '0;
                        state <= obj_pkg::FETCH;
                    end
                end
                obj_pkg::FETCH: begin
                    state <= obj_pkg::WAIT;
                end
                obj_pkg::WAIT: begin
                    if (ram_attr == `OBJ_END_ATTR) begin
                        // End marker, not emitted
                        scan_done <= 1'b1;
                        state     <= obj_pkg::IDLE;
                    end else begin
                        obj_valid <= 1'b1;
                        state     <= obj_pkg::HOLD;
                    end
                end
                obj_pkg::HOLD: begin
                    if (obj_ready) begin
                        obj_valid <= 1'b0;
                        if (idx == LAST_IDX) begin
                            // Bank exhausted without marker
                            scan_done <= 1'b1;
                            state     <= obj_pkg::IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= obj_pkg::FETCH;
                        end
                    end
                end
                default: begin
                    state <= obj_pkg::IDLE;
                end
            endcase
        end
    end

    // Output fields
    // Loaded once per entry, stable while HOLD waits on ready
    always_ff @(posedge clk_cpu) begin
        if (state == obj_pkg::WAIT) begin
            obj_index <= idx;
            obj_x     <= ram_x;
            obj_y     <= ram_y;
            obj_code  <= ram_code;
            obj_attr  <= ram_attr;
        end
    end

endmodule

`default_nettype wire

//--- src/obj_subsys.sv
//------------------------------
// Object subsystem top
// Frame timer, scan FSM and
// double-buffered object RAM
//------------------------------
`default_nettype none

`include "obj_macros.svh"

module obj_subsys (
    input  wire logic               clk_cpu,
    input  wire logic               rst_n,

    // CPU write side
    input  wire logic               cs,
    output logic                    ok,
    input  obj_pkg::obj_be_t        dsn,
    input  wire logic [`OBJ_AW:1]   main_addr,
    input  obj_pkg::obj_word_t      main_dout,

    // Bank control
    input  wire logic               bank_sel,
    output logic                    obank,
    output logic                    frame_start,

    // Sprite stream
    output logic                    obj_valid,
    input  wire logic               obj_ready,
    output obj_pkg::obj_idx_t       obj_index,
    output obj_pkg::obj_word_t      obj_x,
    output obj_pkg::obj_word_t      obj_y,
    output obj_pkg::obj_word_t      obj_code,
    output obj_pkg::obj_word_t      obj_attr,
    output logic                    scan_done
);

    // Display read path, FSM to RAM and back
    obj_pkg::obj_idx_t      obj_addr;
    obj_pkg::obj_word_t     ram_x;
    obj_pkg::obj_word_t     ram_y;
    obj_pkg::obj_word_t     ram_code;
    obj_pkg::obj_word_t     ram_attr;

    obj_frame_timer u_timer (
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .bank_sel       (bank_sel),
        .frame_start    (frame_start),
        .obank          (obank)
    );

    obj_scan_fsm u_scan (
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .frame_start    (frame_start),
        .obj_addr       (obj_addr),
        .ram_x          (ram_x),
        .ram_y          (ram_y),
        .ram_code       (ram_code),
        .ram_attr       (ram_attr),
        .obj_valid      (obj_valid),
        .obj_ready      (obj_ready),
        .obj_index      (obj_index),
        .obj_x          (obj_x),
        .obj_y          (obj_y),
        .obj_code       (obj_code),
        .obj_attr       (obj_attr),
        .scan_done      (scan_done)
    );

    obj_ram u_ram (
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .obank          (obank),
        .cs             (cs),
        .ok             (ok),
        .dsn            (dsn),
        .main_addr      (main_addr),
        .main_dout      (main_dout),
        .obj_addr       (obj_addr),
        .obj_x          (ram_x),
        .obj_y          (ram_y),
        .obj_code       (ram_code),
        .obj_attr       (ram_attr)
    );

endmodule

`default_nettype wire

//--- test/obj_properties.sv
//------------------------------
// Concurrent checks on the
// object subsystem, with bind
//------------------------------
`default_nettype none

module obj_properties (
    input wire logic                clk_cpu,
    input wire logic                rst_n,
    input wire logic                cs,
    input wire logic                ok,
    input wire logic                obank,
    input wire logic                frame_start,
    input wire logic                obj_valid,
    input wire logic                obj_ready,
    input wire obj_pkg::obj_idx_t   obj_index,
    input wire obj_pkg::obj_word_t  obj_x,
    input wire obj_pkg::obj_word_t  obj_y,
    input wire obj_pkg::obj_word_t  obj_code,
    input wire obj_pkg::obj_word_t  obj_attr
);

    // Number of failed checks
    int assert_fails = 0;

    // Ack is cs delayed by one cycle
    a_ok_follows_cs: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        ok == $past(cs))
        else begin
            assert_fails++;
            $error("ok is not cs delayed by one cycle");
        end

    // Stalled entry keeps valid and all fields
    a_hold_stable: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        obj_valid && !obj_ready |=>
            obj_valid && $stable({obj_index, obj_x, obj_y, obj_code, obj_attr}))
        else begin
            assert_fails++;
            $error("sprite fields moved while stalled");
        end

    // Bank swap only on frame boundaries
    a_bank_on_frame: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        $changed(obank) |-> frame_start)
        else begin
            assert_fails++;
            $error("obank changed without frame_start");
        end

    a_valid_after_reset: assert property (@(posedge clk_cpu) !rst_n |=> !obj_valid)
        else begin
            assert_fails++;
            $error("obj_valid high after reset");
        end

endmodule

bind obj_subsys obj_properties u_props (
    .clk_cpu        (clk_cpu),
    .rst_n          (rst_n),
    .cs             (cs),
    .ok             (ok),
    .obank          (obank),
    .frame_start    (frame_start),
    .obj_valid      (obj_valid),
    .obj_ready      (obj_ready),
    .obj_index      (obj_index),
    .obj_x          (obj_x),
    .obj_y          (obj_y),
    .obj_code       (obj_code),
    .obj_attr       (obj_attr)
);

`default_nettype wire

//--- test/obj_subsys_tb.sv
//------------------------------
// Object subsystem testbench
// Bank model, directed tests,
// compare tasks, final report
//------------------------------
`default_nettype none

`include "obj_macros.svh"

module obj_subsys_tb;

    localparam int ENTRIES    = `OBJ_ENTRIES;
    localparam int WAIT_FRAME = 2 * `OBJ_FRAME_CYCLES + 8;
    localparam int WAIT_SCAN  = 8 * ENTRIES + 16;

    logic               clk_cpu;
    logic               rst_n;
    logic               cs;
    logic               ok;
    obj_pkg::obj_be_t   dsn;
    logic [`OBJ_AW:1]   main_addr;
    obj_pkg::obj_word_t main_dout;
    logic               bank_sel;
    logic               obank;
    logic               frame_start;
    logic               obj_valid;
    logic               obj_ready;
    obj_pkg::obj_idx_t  obj_index;
    obj_pkg::obj_word_t obj_x;
    obj_pkg::obj_word_t obj_y;
    obj_pkg::obj_word_t obj_code;
    obj_pkg::obj_word_t obj_attr;
    logic               scan_done;

    // Model of both physical banks
    // Field order X Y code attr
    obj_pkg::obj_word_t model [2][ENTRIES][4];
    // Bank the CPU side should be on
    logic               exp_bank;

    // Entries taken in the last scan
    // Fields packed as X Y code attr
    obj_pkg::obj_idx_t  got_idx [$];
    logic [63:0]        got_f [$];

    int                 word_errs;
    int                 index_errs;
    int                 bit_errs;
    int                 length_errs;
    int                 timing_errs;
    bit                 timed_out;
    integer             seed;

    obj_subsys UUT (.*);

    initial clk_cpu = 1'b0;
    always #4 clk_cpu = ~clk_cpu;

    task automatic check_word(input obj_pkg::obj_word_t got, input obj_pkg::obj_word_t exp,
                              input string what);
        if (got !== exp) begin
            word_errs++;
            $display("Fail t=%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_index(input obj_pkg::obj_idx_t got, input obj_pkg::obj_idx_t exp,
                               input string what);
        if (got !== exp) begin
            index_errs++;
            $display("Fail t=%0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            bit_errs++;
            $display("Fail t=%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            timing_errs++;
            $display("Fail t=%0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    // Inputs move 1 unit past the edge
    task automatic next_cycle();
        @(posedge clk_cpu);
        #1;
    endtask

    function automatic obj_pkg::obj_word_t rand_word();
        return obj_pkg::obj_word_t'($random(seed));
    endfunction

    // Random attribute that never ends the table
    function automatic obj_pkg::obj_word_t rand_attr();
        obj_pkg::obj_word_t w;
        w = rand_word();
        if (w == `OBJ_END_ATTR) begin
            w = w ^ 16'h0001;
        end
        return w;
    endfunction

    // One CPU write with ok high in the next cycle only
    task automatic write_word(input logic hi, input int entry, input int field,
                              input obj_pkg::obj_be_t lanes_n, input obj_pkg::obj_word_t data);
        logic phys;
        phys      = hi ^ exp_bank;
        cs        = 1'b1;
        dsn       = lanes_n;
        main_addr = {hi, obj_pkg::obj_idx_t'(entry), 2'(field)};
        main_dout = data;
        next_cycle();
        cs  = 1'b0;
        dsn = 2'b11;
        check_bit(ok, 1'b1, "ok after cs");
        next_cycle();
        check_bit(ok, 1'b0, "ok one cycle later");
        // Only low dsn lanes land
        if (!lanes_n[0]) begin
            model[phys][entry][field][7:0] = data[7:0];
        end
        if (!lanes_n[1]) begin
            model[phys][entry][field][15:8] = data[15:8];
        end
    endtask

    // n random entries and an optional end marker at entry n
    task automatic load_entries(input logic hi, input int n, input bit marker);
        for (int e = 0; e < n + int'(marker); e++) begin
            write_word(hi, e, 0, 2'b00, rand_word());
            write_word(hi, e, 1, 2'b00, rand_word());
            write_word(hi, e, 2, 2'b00, rand_word());
            write_word(hi, e, 3, 2'b00, (e == n) ? `OBJ_END_ATTR : rand_attr());
        end
    endtask

    task automatic wait_frame(input string why);
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!frame_start && n < WAIT_FRAME);
        if (!frame_start) begin
            timed_out = 1'b1;
            $display("Timeout: no frame start while waiting for %s", why);
        end else begin
            // Bank request is latched on this pulse
            exp_bank = bank_sel;
            check_bit(obank, exp_bank, "obank at frame start");
        end
    endtask

    task automatic collect_scan(input bit backpressure);
        int n;
        int first_valid;
        bit done;
        got_idx.delete();
        got_f.delete();
        n           = 0;
        first_valid = -1;
        done        = 1'b0;
        while (!done && n < WAIT_SCAN) begin
            next_cycle();
            obj_ready = backpressure ? 1'($random(seed)) : 1'b1;
            // Frame start lasts a single cycle
            if (n == 0) begin
                check_bit(frame_start, 1'b0, "frame_start one cycle after pulse");
            end
            // Cycles counted from the frame start cycle
            if (obj_valid && first_valid < 0) begin
                first_valid = n + 1;
            end
            // Transfer completes at the coming edge
            if (obj_valid && obj_ready) begin
                got_idx.push_back(obj_index);
                got_f.push_back({obj_x, obj_y, obj_code, obj_attr});
            end
            done = scan_done;
            n++;
        end
        obj_ready = 1'b1;
        if (!done) begin
            timed_out = 1'b1;
            $display("Timeout: scan never signalled scan_done");
        end else begin
            check_cycles(first_valid, 3, "frame_start to first obj_valid");
            // Done is a single-cycle pulse
            next_cycle();
            check_bit(scan_done, 1'b0, "scan_done one cycle later");
        end
    endtask

    task automatic check_scan(input string name);
        int disp;
        int n_exp;
        disp  = int'(!exp_bank);
        n_exp = 0;
        // Stop before the marker or at the bank end
        while (n_exp < ENTRIES && model[disp][n_exp][3] !== `OBJ_END_ATTR) begin
            n_exp++;
        end
        if (got_idx.size() != n_exp) begin
            length_errs++;
            $display("Fail t=%0t: %s scan gave %0d entries, expected %0d",
                     $time, name, got_idx.size(), n_exp);
        end
        for (int k = 0; k < n_exp && k < got_idx.size(); k++) begin
            check_index(got_idx[k], obj_pkg::obj_idx_t'(k), {name, " index"});
            check_word(got_f[k][63:48], model[disp][k][0], {name, " x"});
            check_word(got_f[k][47:32], model[disp][k][1], {name, " y"});
            check_word(got_f[k][31:16], model[disp][k][2], {name, " code"});
            check_word(got_f[k][15:0], model[disp][k][3], {name, " attr"});
        end
    endtask

    task automatic swap_and_scan(input logic sel, input bit backpressure, input string name);
        bank_sel = sel;
        wait_frame(name);
        if (!timed_out) begin
            collect_scan(backpressure);
        end
        if (!timed_out) begin
            check_scan(name);
        end
    endtask

    task automatic test_reset();
        check_bit(ok, 1'b0, "ok after reset");
        check_bit(obj_valid, 1'b0, "obj_valid after reset");
        check_bit(scan_done, 1'b0, "scan_done after reset");
        check_bit(frame_start, 1'b0, "frame_start after reset");
        check_bit(obank, 1'b0, "obank after reset");
        // Isolated writes that are each acked once
        for (int f = 0; f < 4; f++) begin
            write_word(1'b0, ENTRIES - 1, f, 2'b00, rand_word());
        end
    endtask

    task automatic test_byte_lanes();
        // Bank bit set reaches the displayed bank
        for (int e = 0; e < 8; e++) begin
            write_word(1'b1, e, e % 3, (e % 2 == 0) ? 2'b10 : 2'b01, rand_word());
        end
        swap_and_scan(1'b1, 1'b0, "byte lanes");
    endtask

    task automatic test_bank_isolation();
        load_entries(1'b0, 6, 1'b1);
        swap_and_scan(1'b1, 1'b0, "old bank kept");
        swap_and_scan(1'b0, 1'b0, "new bank shown");
    endtask

    initial begin
        seed        = 56;
        word_errs   = 0;
        index_errs  = 0;
        bit_errs    = 0;
        length_errs = 0;
        timing_errs = 0;
        timed_out   = 1'b0;
        exp_bank    = 1'b0;
        rst_n       = 1'b0;
        cs          = 1'b0;
        dsn         = 2'b11;
        main_addr   = '0;
        main_dout   = '0;
        bank_sel    = 1'b0;
        obj_ready   = 1'b1;
        repeat (5) @(posedge clk_cpu);
        #1 rst_n = 1'b1;

        test_reset();
        if (!timed_out) begin
            load_entries(1'b0, 8, 1'b1);
            swap_and_scan(1'b1, 1'b0, "write and swap");
        end
        if (!timed_out) begin
            test_byte_lanes();
        end
        if (!timed_out) begin
            test_bank_isolation();
        end
        if (!timed_out) begin
            load_entries(1'b0, 12, 1'b1);
            swap_and_scan(1'b1, 1'b1, "back-pressure");
        end
        if (!timed_out) begin
            // Whole bank with no marker
            load_entries(1'b0, ENTRIES, 1'b0);
            swap_and_scan(1'b0, 1'b0, "end of table");
        end

        $display("Errors: word %0d, index %0d, control %0d, length %0d, ",
                 word_errs, index_errs, bit_errs, length_errs,
                 "timing %0d, assertion %0d, timeout %0d",
                 timing_errs, UUT.u_props.assert_fails, timed_out);
        if (word_errs + index_errs + bit_errs + length_errs + timing_errs
            + UUT.u_props.assert_fails == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- obj_subsys.f
+incdir+src
src/obj_pkg.sv
src/obj_dpram.sv
src/obj_ram.sv
src/obj_frame_timer.sv
src/obj_scan_fsm.sv
src/obj_subsys.sv
test/obj_properties.sv
test/obj_subsys_tb.sv

//--- Makefile
# Verilator flow for the object subsystem

VERILATOR ?= verilator
TOP       ?= obj_subsys_tb
FILELIST  ?= obj_subsys.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Result comes from the simulation output, no log kept
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
